/* pic_pkg.sv */
// Shared definitions for the interrupt controller
// Register map, field widths, port and tree structs, priority compare
package pic_pkg;

  localparam int PRIO_BITS = 4;
  localparam int ID_BITS   = 8;    // Up to 256 sources

  //////////////////////////////
  // Register block offsets
  //////////////////////////////
  localparam logic [31:0] OFS_PRIORITY  = 32'h0000_0000;
  localparam logic [31:0] OFS_PENDING   = 32'h0000_1000;  // Read as 32-bit words
  localparam logic [31:0] OFS_ENABLE    = 32'h0000_2000;
  localparam logic [31:0] OFS_CONFIG    = 32'h0000_3000;  // Single word, bit 0 reverses order
  localparam logic [31:0] OFS_GW_CONFIG = 32'h0000_4000;  // Bit 1 type, bit 0 polarity
  localparam logic [31:0] OFS_GW_CLEAR  = 32'h0000_5000;

  // Register access from the core, one cycle per access
  typedef struct packed {
    logic        rden;
    logic [31:0] rdaddr;
    logic        wren;
    logic [31:0] wraddr;
    logic [31:0] wr_data;
  } pic_req_t;

  // Notification to the core
  typedef struct packed {
    logic                 req;      // External interrupt pending
    logic [ID_BITS-1:0]   claimid;
    logic [PRIO_BITS-1:0] pl;       // Level on the programmed scale
    logic                 wakeup;
  } pic_irq_t;

  // One node of the priority tree
  typedef struct packed {
    logic [PRIO_BITS-1:0] prio;
    logic [ID_BITS-1:0]   id;
  } pic_cand_t;

  // Higher priority wins, first operand on a tie
  function automatic pic_cand_t pic_max(pic_cand_t a, pic_cand_t b);
    return (a.prio < b.prio) ? b : a;
  endfunction

endpackage

/* pic_gateways.sv */
// Source synchronizers and level/edge gateways with polarity
`timescale 1ns/1ps

module pic_gateways #(
  parameter int NUM_SRC = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [NUM_SRC-1:0] extintsrc_req,
  input  logic [NUM_SRC-1:0] gw_type,      // 1 = edge
  input  logic [NUM_SRC-1:0] gw_polarity,  // 1 = active low
  input  logic [NUM_SRC-1:0] gw_clear,
  output logic [NUM_SRC-1:0] pend
);

  localparam logic [NUM_SRC-1:0] SRC_MASK = ~NUM_SRC'(1);  // Source 0 is reserved

  logic [NUM_SRC-1:0] sync_q1;
  logic [NUM_SRC-1:0] sync_q2;
  logic [NUM_SRC-1:0] sticky_q;
  logic [NUM_SRC-1:0] level;

  assign level = sync_q2 ^ gw_polarity;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q1  <= '0;
      sync_q2  <= '0;
      sticky_q <= '0;
    end else begin
      sync_q1  <= extintsrc_req;
      sync_q2  <= sync_q1;
      // Edge sources hold until software clears them
      sticky_q <= gw_type & (level | (sticky_q & ~gw_clear));
    end
  end

  assign pend = (level | (gw_type & sticky_q)) & SRC_MASK;

endmodule

/* pic_regs.sv */
// Register port of the interrupt controller
// Request flop, address decode, configuration registers and read mux
`timescale 1ns/1ps

module pic_regs #(
  parameter int          NUM_SRC   = 32,
  parameter logic [31:0] BASE_ADDR = 32'hF00C_0000
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  pic_pkg::pic_req_t                          req,
  input  logic [NUM_SRC-1:0]                         pend,
  output logic [31:0]                                rd_data,
  output logic [NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0] prio,
  output logic [NUM_SRC-1:0]                         enable,
  output logic [NUM_SRC-1:0]                         gw_type,
  output logic [NUM_SRC-1:0]                         gw_polarity,
  output logic [NUM_SRC-1:0]                         gw_clear,
  output logic                                       prio_order
);

  import pic_pkg::*;

  localparam int IDX_BITS   = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;
  localparam int PEND_WORDS = (NUM_SRC + 31) / 32;
  localparam int PEND_BITS  = PEND_WORDS * 32;

  localparam logic [31:0] PRIO_ADDR   = BASE_ADDR + OFS_PRIORITY;
  localparam logic [31:0] PEND_ADDR   = BASE_ADDR + OFS_PENDING;
  localparam logic [31:0] ENABLE_ADDR = BASE_ADDR + OFS_ENABLE;
  localparam logic [31:0] CONFIG_ADDR = BASE_ADDR + OFS_CONFIG;
  localparam logic [31:0] GWCFG_ADDR  = BASE_ADDR + OFS_GW_CONFIG;
  localparam logic [31:0] GWCLR_ADDR  = BASE_ADDR + OFS_GW_CLEAR;

  pic_req_t            req_q;
  logic [IDX_BITS-1:0] ridx;
  logic [IDX_BITS-1:0] widx;
  logic                rd_prio, rd_enable, rd_gwcfg, rd_pend, rd_config;
  logic                wr_prio, wr_enable, wr_gwcfg, wr_clear, wr_config;
  logic [PEND_BITS-1:0] pend_ext;
  logic [31:0]         pend_word;

  // Block hit on the bits above the source index
  function automatic logic blk_hit(logic [31:0] addr, logic [31:0] base);
    return addr[31:IDX_BITS+2] == base[31:IDX_BITS+2];
  endfunction

  //////////////////////////////
  // Request flop
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= req;
    end
  end

  assign ridx = req_q.rdaddr[IDX_BITS+1:2];
  assign widx = req_q.wraddr[IDX_BITS+1:2];

  assign rd_prio   = req_q.rden & blk_hit(req_q.rdaddr, PRIO_ADDR);
  assign rd_enable = req_q.rden & blk_hit(req_q.rdaddr, ENABLE_ADDR);
  assign rd_gwcfg  = req_q.rden & blk_hit(req_q.rdaddr, GWCFG_ADDR);
  assign rd_pend   = req_q.rden & (req_q.rdaddr[31:6] == PEND_ADDR[31:6]);
  assign rd_config = req_q.rden & (req_q.rdaddr == CONFIG_ADDR);

  assign wr_prio   = req_q.wren & blk_hit(req_q.wraddr, PRIO_ADDR);
  assign wr_enable = req_q.wren & blk_hit(req_q.wraddr, ENABLE_ADDR);
  assign wr_gwcfg  = req_q.wren & blk_hit(req_q.wraddr, GWCFG_ADDR);
  assign wr_clear  = req_q.wren & blk_hit(req_q.wraddr, GWCLR_ADDR);
  assign wr_config = req_q.wren & (req_q.wraddr == CONFIG_ADDR);

  //////////////////////////////
  // Configuration registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio        <= '0;
      enable      <= '0;
      gw_type     <= '0;
      gw_polarity <= '0;
      prio_order  <= 1'b0;
    end else begin
      for (int i = 1; i < NUM_SRC; i++) begin  // Source 0 stays zero
        if (widx == i) begin
          if (wr_prio) prio[i] <= req_q.wr_data[PRIO_BITS-1:0];
          if (wr_enable) enable[i] <= req_q.wr_data[0];
          if (wr_gwcfg) begin
            gw_type[i]     <= req_q.wr_data[1];
            gw_polarity[i] <= req_q.wr_data[0];
          end
        end
      end
      if (wr_config) prio_order <= req_q.wr_data[0];
    end
  end

  always_comb begin
    gw_clear = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      gw_clear[i] = wr_clear & (widx == i);  // One-cycle pulse
    end
  end

  //////////////////////////////
  // Read data
  //////////////////////////////
  assign pend_ext = PEND_BITS'(pend);

  always_comb begin
    pend_word = '0;
    for (int w = 0; w < PEND_WORDS; w++) begin
      if (req_q.rdaddr[5:2] == w) pend_word = pend_ext[w*32 +: 32];
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (ridx == i) begin
        if (rd_prio) rd_data = 32'(prio[i]);
        if (rd_enable) rd_data = 32'(enable[i]);
        if (rd_gwcfg) rd_data = 32'({gw_type[i], gw_polarity[i]});
      end
    end
    if (rd_pend) rd_data = pend_word;
    if (rd_config) rd_data = 32'(prio_order);
  end

endmodule

/* pic_prio_tree.sv */
// Effective priority per source and the maximum-priority search tree
`timescale 1ns/1ps

module pic_prio_tree #(
  parameter int NUM_SRC = 32
) (
  input  logic [NUM_SRC-1:0][pic_pkg::PRIO_BITS-1:0] prio,
  input  logic [NUM_SRC-1:0]                         enable,
  input  logic [NUM_SRC-1:0]                         pend,
  input  logic                                       prio_order,
  output pic_pkg::pic_cand_t                         best
);

  import pic_pkg::*;

  localparam int LEVELS = $clog2(NUM_SRC);
  localparam int LEAVES = 2 ** LEVELS;   // Padded to a power of two

  pic_cand_t [LEAVES-1:0] node [LEVELS+1];

  always_comb begin
    for (int l = 0; l <= LEVELS; l++) begin
      node[l] = '0;
    end

    //////////////////////////////
    // Leaves
    //////////////////////////////
    for (int i = 0; i < NUM_SRC; i++) begin
      node[0][i].prio = (prio_order ? ~prio[i] : prio[i]) &
                        {PRIO_BITS{pend[i] & enable[i]}};
      node[0][i].id   = ID_BITS'(i);
    end

    // Pairwise reduction, even node is the lower ID and wins ties
    for (int l = 0; l < LEVELS; l++) begin
      for (int m = 0; m < (LEAVES >> (l + 1)); m++) begin
        node[l+1][m] = pic_max(node[l][2*m], node[l][2*m+1]);
      end
    end
  end

  assign best = node[LEVELS][0];

endmodule

/* pic_notify.sv */
// Threshold compare and the registered notification to the core
`timescale 1ns/1ps

module pic_notify (
  input  logic                        clk,
  input  logic                        rst_n,
  input  pic_pkg::pic_cand_t          best,
  input  logic                        prio_order,
  input  logic [pic_pkg::PRIO_BITS-1:0] meipt,
  input  logic [pic_pkg::PRIO_BITS-1:0] meicurpl,
  output pic_pkg::pic_irq_t           irq
);

  import pic_pkg::*;

  logic [PRIO_BITS-1:0] meipt_eff;
  logic [PRIO_BITS-1:0] meicurpl_eff;
  logic [PRIO_BITS-1:0] pl_d;
  logic [PRIO_BITS-1:0] max_pl;
  pic_irq_t             irq_d;

  // Thresholds moved onto the tree's scale
  assign meipt_eff    = prio_order ? ~meipt : meipt;
  assign meicurpl_eff = prio_order ? ~meicurpl : meicurpl;

  assign pl_d   = prio_order ? ~best.prio : best.prio;  // Back to programmed scale
  assign max_pl = prio_order ? '0 : '1;

  assign irq_d.req     = (best.prio > meipt_eff) & (best.prio > meicurpl_eff);
  assign irq_d.claimid = best.id;
  assign irq_d.pl      = pl_d;
  assign irq_d.wakeup  = (pl_d == max_pl);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      irq <= '0;
    end else begin
      irq <= irq_d;
    end
  end

endmodule

/* pic_ctrl.sv */
// Interrupt controller top level
// Gateways, register port, priority tree and core notification
`timescale 1ns/1ps

module pic_ctrl #(
  parameter int          NUM_SRC   = 32,
  parameter logic [31:0] BASE_ADDR = 32'hF00C_0000
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [NUM_SRC-1:0]            extintsrc_req,
  input  pic_pkg::pic_req_t             req,
  input  logic [pic_pkg::PRIO_BITS-1:0] meipt,
  input  logic [pic_pkg::PRIO_BITS-1:0] meicurpl,
  output logic [31:0]                   rd_data,
  output pic_pkg::pic_irq_t             irq
);

  import pic_pkg::*;

  logic [NUM_SRC-1:0]                pend;
  logic [NUM_SRC-1:0][PRIO_BITS-1:0] prio;
  logic [NUM_SRC-1:0]                enable;
  logic [NUM_SRC-1:0]                gw_type;
  logic [NUM_SRC-1:0]                gw_polarity;
  logic [NUM_SRC-1:0]                gw_clear;
  logic                              prio_order;
  pic_cand_t                         best;

  pic_gateways #(.NUM_SRC(NUM_SRC)) u_gateways (
    .clk           (clk),
    .rst_n         (rst_n),
    .extintsrc_req (extintsrc_req),
    .gw_type       (gw_type),
    .gw_polarity   (gw_polarity),
    .gw_clear      (gw_clear),
    .pend          (pend)
  );

  pic_regs #(.NUM_SRC(NUM_SRC), .BASE_ADDR(BASE_ADDR)) u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .pend        (pend),
    .rd_data     (rd_data),
    .prio        (prio),
    .enable      (enable),
    .gw_type     (gw_type),
    .gw_polarity (gw_polarity),
    .gw_clear    (gw_clear),
    .prio_order  (prio_order)
  );

  pic_prio_tree #(.NUM_SRC(NUM_SRC)) u_prio_tree (
    .prio       (prio),
    .enable     (enable),
    .pend       (pend),
    .prio_order (prio_order),
    .best       (best)
  );

  pic_notify u_notify (
    .clk        (clk),
    .rst_n      (rst_n),
    .best       (best),
    .prio_order (prio_order),
    .meipt      (meipt),
    .meicurpl   (meicurpl),
    .irq        (irq)
  );

endmodule

/* tb_pic_ctrl.sv */
// Testbench for the interrupt controller
// Register shadow, gateway model, reference notification and checks
`timescale 1ns/1ps

module tb_pic_ctrl;

  import pic_pkg::*;

  localparam int          NUM_SRC = 32;
  localparam logic [31:0] BASE    = 32'hF00C_0000;
  localparam int          TIMEOUT = 20;   // Pending word reads before giving up

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [NUM_SRC-1:0]   src;
  pic_req_t             req;
  logic [PRIO_BITS-1:0] meipt;
  logic [PRIO_BITS-1:0] meicurpl;
  logic [31:0]          rd_data;
  pic_irq_t             irq;

  // Shadow of the programmed registers and of the sticky edge bits
  logic [PRIO_BITS-1:0] prio_sh [NUM_SRC];
  logic [NUM_SRC-1:0]   en_sh, type_sh, pol_sh, sticky_sh;
  logic                 order_sh;
  logic [31:0]          rng;
  logic [31:0]          rdat;

  pic_ctrl #(.NUM_SRC(NUM_SRC), .BASE_ADDR(BASE)) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .extintsrc_req (src),
    .req           (req),
    .meipt         (meipt),
    .meicurpl      (meicurpl),
    .rd_data       (rd_data),
    .irq           (irq)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Level for level sources, level or latched bit for edge sources
  function automatic logic [NUM_SRC-1:0] model_pend();
    logic [NUM_SRC-1:0] p;
    logic               active;
    p = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      active = (src[i] != pol_sh[i]);
      p[i]   = type_sh[i] ? (active || sticky_sh[i]) : active;
    end
    return p;
  endfunction

  // Upward scan, so a tie keeps the lower ID
  function automatic pic_irq_t ref_irq();
    pic_irq_t             r;
    logic [NUM_SRC-1:0]   p;
    logic [PRIO_BITS-1:0] eff;
    logic [PRIO_BITS-1:0] top;
    p   = model_pend();
    top = '0;
    r   = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      eff = order_sh ? 4'd15 - prio_sh[i] : prio_sh[i];
      if (p[i] && en_sh[i] && eff > top) begin
        top       = eff;
        r.claimid = ID_BITS'(i);
      end
    end
    r.req    = (top > (order_sh ? 4'd15 - meipt : meipt)) &&
               (top > (order_sh ? 4'd15 - meicurpl : meicurpl));
    r.pl     = order_sh ? 4'd15 - top : top;
    r.wakeup = (r.pl == (order_sh ? 4'd0 : 4'd15));
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic settle();
    for (int n = 0; n < 3; n++) @(posedge clk);
    @(negedge clk);  // Sample away from the edge
  endtask

  //////////////////////////////
  // Register port access
  //////////////////////////////
  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    req.wren    <= 1'b1;
    req.wraddr  <= addr;
    req.wr_data <= data;
    @(posedge clk);
    req.wren    <= 1'b0;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    req.rden   <= 1'b1;
    req.rdaddr <= addr;
    @(posedge clk);
    req.rden   <= 1'b0;
    @(negedge clk);
    data = rd_data;
  endtask

  // Source 0 is never stored
  task automatic write_src(input logic [31:0] ofs, input int i, input logic [31:0] d);
    reg_write(BASE + ofs + 32'(4 * i), d);
    case (ofs)
      OFS_PRIORITY:  if (i != 0) prio_sh[i] = d[PRIO_BITS-1:0];
      OFS_ENABLE:    if (i != 0) en_sh[i] = d[0];
      OFS_GW_CONFIG: if (i != 0) {type_sh[i], pol_sh[i]} = d[1:0];
      OFS_GW_CLEAR:  sticky_sh[i] = 1'b0;
      default:       order_sh = d[0];
    endcase
    sticky_sh = type_sh & (sticky_sh | (src ^ pol_sh));  // Active edge source relatches
  endtask

  task automatic read_back(input logic [31:0] ofs, input int i);
    logic [31:0] exp;
    case (ofs)
      OFS_PRIORITY:  exp = 32'(prio_sh[i]);
      OFS_ENABLE:    exp = 32'(en_sh[i]);
      OFS_GW_CONFIG: exp = 32'({type_sh[i], pol_sh[i]});
      default:       exp = 32'(order_sh);
    endcase
    reg_read(BASE + ofs + 32'(4 * i), rdat);
    check("rd_data", rdat, exp);
  endtask

  task automatic drive_src(input logic [NUM_SRC-1:0] v);
    @(posedge clk);
    src <= v;
    sticky_sh = type_sh & (sticky_sh | (v ^ pol_sh));
  endtask

  task automatic check_irq();
    pic_irq_t e;
    e = ref_irq();
    check("irq.req", 32'(irq.req), 32'(e.req));
    check("irq.claimid", 32'(irq.claimid), 32'(e.claimid));
    check("irq.pl", 32'(irq.pl), 32'(e.pl));
    check("irq.wakeup", 32'(irq.wakeup), 32'(e.wakeup));
  endtask

  // Polls the pending word until it agrees with the gateway model
  task automatic expect_pend();
    int n;
    n = 0;
    reg_read(BASE + OFS_PENDING, rdat);
    while (rdat !== 32'(model_pend())) begin
      if (n == TIMEOUT) begin
        $display("wait for the pending word expired after %0d reads", TIMEOUT);
        check("pending", rdat, 32'(model_pend()));
      end
      n++;
      reg_read(BASE + OFS_PENDING, rdat);
    end
  endtask

  initial begin
    rng       = 32'hee43_2064;
    rst_n     = 1'b0;
    src       = '0;
    req       = '0;
    meipt     = '0;
    meicurpl  = '0;
    en_sh     = '0;
    type_sh   = '0;
    pol_sh    = '0;
    sticky_sh = '0;
    order_sh  = 1'b0;
    for (int i = 0; i < NUM_SRC; i++) prio_sh[i] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    settle();
    check("irq", 32'(irq), 32'h0);
    for (int i = 0; i < NUM_SRC; i++) begin
      read_back(OFS_PRIORITY, i);
      read_back(OFS_ENABLE, i);
      read_back(OFS_GW_CONFIG, i);
    end
    read_back(OFS_CONFIG, 0);
    expect_pend();

    // Random writes read back zero-extended
    for (int i = 0; i < NUM_SRC; i++) begin
      write_src(OFS_PRIORITY, i, next_random());
      write_src(OFS_ENABLE, i, next_random());
      write_src(OFS_GW_CONFIG, i, next_random());
      read_back(OFS_PRIORITY, i);
      read_back(OFS_ENABLE, i);
      read_back(OFS_GW_CONFIG, i);
    end
    write_src(OFS_CONFIG, 0, next_random());
    read_back(OFS_CONFIG, 0);
    write_src(OFS_CONFIG, 0, 0);

    //////////////////////////////
    // Arbitration, level sources
    //////////////////////////////
    for (int i = 1; i < NUM_SRC; i++) write_src(OFS_GW_CONFIG, i, 0);
    for (int r = 0; r < 8; r++) begin
      for (int i = 1; i < NUM_SRC; i++) begin
        write_src(OFS_PRIORITY, i, next_random());
        write_src(OFS_ENABLE, i, next_random());
      end
      drive_src(next_random());
      settle();
      check_irq();
    end
    for (int i = 1; i < NUM_SRC; i++) write_src(OFS_PRIORITY, i, (i == 7 || i == 12) ? 9 : 2);
    write_src(OFS_ENABLE, 7, 1);
    write_src(OFS_ENABLE, 12, 1);
    drive_src(src | 32'h1080);
    settle();
    check_irq();
    check("irq.claimid", 32'(irq.claimid), 7);   // Tie

    // Threshold and current level sweep
    for (int a = 0; a < 16; a++) begin
      for (int b = 0; b < 16; b++) begin
        @(posedge clk);
        meipt    <= 4'(a);
        meicurpl <= 4'(b);
        settle();
        check_irq();
      end
    end
    write_src(OFS_PRIORITY, 12, 15);
    settle();
    check_irq();
    check("irq.wakeup", 32'(irq.wakeup), 1);

    //////////////////////////////
    // Edge gateway and polarity
    //////////////////////////////
    @(posedge clk);
    meipt    <= '0;
    meicurpl <= '0;
    drive_src('0);
    write_src(OFS_GW_CONFIG, 9, 32'h2);
    write_src(OFS_PRIORITY, 9, 13);
    write_src(OFS_ENABLE, 9, 1);
    drive_src(NUM_SRC'(1) << 9);
    drive_src('0);   // One-cycle pulse
    expect_pend();
    settle();
    check_irq();
    check("irq.claimid", 32'(irq.claimid), 9);
    repeat (10) @(posedge clk);
    expect_pend();
    check_irq();
    write_src(OFS_GW_CLEAR, 9, 0);
    settle();
    check_irq();
    expect_pend();
    write_src(OFS_GW_CONFIG, 4, 32'h1);
    write_src(OFS_PRIORITY, 4, 5);
    write_src(OFS_ENABLE, 4, 1);
    settle();
    expect_pend();
    check_irq();
    drive_src(NUM_SRC'(1) << 4);
    settle();
    expect_pend();
    check_irq();

    // Reversed priority order
    write_src(OFS_CONFIG, 0, 1);
    settle();
    check_irq();
    for (int r = 0; r < 8; r++) begin
      for (int i = 1; i < NUM_SRC; i++) begin
        write_src(OFS_PRIORITY, i, next_random());
      end
      drive_src(next_random());
      @(posedge clk);
      meipt    <= 4'(next_random());
      meicurpl <= 4'(next_random());
      settle();
      check_irq();
    end
    write_src(OFS_PRIORITY, 3, 0);
    write_src(OFS_ENABLE, 3, 1);
    drive_src(src | 32'h8);
    settle();
    check_irq();
    check("irq.wakeup", 32'(irq.wakeup), 1);

    $display("TB PASSED");
    $finish;
  end

endmodule

/* filelist.f */
pic_pkg.sv
pic_gateways.sv
pic_regs.sv
pic_prio_tree.sv
pic_notify.sv
pic_ctrl.sv
tb_pic_ctrl.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pic_ctrl -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_pic_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
